/* design/bridge_config.svh */
`ifndef BRIDGE_CONFIG_SVH
`define BRIDGE_CONFIG_SVH

// link id, matched against mesh address bits 31:20
`define BRIDGE_ELINK_ID    12'h810

// register group codes in address bits 19:16
`define BRIDGE_GROUP_MMR   4'hF
`define BRIDGE_GROUP_RXMMU 4'hE
`define BRIDGE_GROUP_TXMMU 4'hD
`define BRIDGE_GROUP_EMBOX 4'hC

`define BRIDGE_AXI_ADDR_W  30   // axi byte address width

`endif

/* design/axi_types_pkg.sv */
`default_nettype none

`include "bridge_config.svh"

package axi_types_pkg;

   typedef logic [`BRIDGE_AXI_ADDR_W-1:0] axi_addr_t;   // byte address
   typedef logic [7:0]  axi_len_t;    // beats minus one
   typedef logic [2:0]  axi_size_t;   // log2 of bytes per beat
   typedef logic [3:0]  axi_strb_t;   // one bit per byte lane
   typedef logic [31:0] axi_data_t;
   typedef logic [1:0]  axi_resp_t;   // bridge only ever answers okay

   // burst type, wrap gets the fixed behaviour
   typedef enum logic [1:0]
   {
      FIXED = 2'b00,
      INCR  = 2'b01,
      WRAP  = 2'b10
   } axi_burst_e;

endpackage

`default_nettype wire

/* design/emesh_types_pkg.sv */
`default_nettype none

package emesh_types_pkg;

   typedef logic [31:0] emesh_addr_t;   // coreid sits in 31:20
   typedef logic [31:0] emesh_data_t;
   typedef logic [1:0]  datamode_t;     // 0 byte, 1 half, 2 word
   typedef logic [3:0]  ctrlmode_t;
   typedef logic [11:0] coreid_t;
   typedef logic [19:0] mi_addr_t;      // offset inside the link window

   // write channel, one burst at a time
   typedef enum logic [1:0] { WR_IDLE, WR_DATA, WR_RESP } wr_state_e;

   // read channel, one transaction in flight
   typedef enum logic { RD_IDLE, RD_DATA } rd_state_e;

endpackage

`default_nettype wire

/* design/axi_slave_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module axi_slave_ctrl
(
   input  logic                     s_axi_aclk,
   input  logic                     s_axi_aresetn,
   input  logic                     s_axi_awvalid,
   output logic                     s_axi_awready,
   input  logic                     s_axi_wvalid,
   input  logic                     s_axi_wlast,
   output logic                     s_axi_wready,
   input  logic                     s_axi_bready,
   output logic                     s_axi_bvalid,
   output axi_types_pkg::axi_resp_t s_axi_bresp,
   input  logic                     s_axi_arvalid,
   output logic                     s_axi_arready,
   input  logic                     s_axi_rready,
   input  logic                     rvalid,
   input  logic                     rlast,
   input  logic                     emwr_progfull,
   output logic                     aw_accept,
   output logic                     w_beat,
   output logic                     ar_accept,
   output logic                     r_beat,
   output logic                     read_start
);
   import emesh_types_pkg::*;

   wr_state_e wr_state;
   rd_state_e rd_state;
   logic      w_last_beat;   // closing data beat of the burst
   logic      r_last_beat;

   assign aw_accept   = s_axi_awvalid & s_axi_awready;
   assign w_beat      = s_axi_wvalid & s_axi_wready;
   assign ar_accept   = s_axi_arvalid & s_axi_arready;
   assign r_beat      = rvalid & s_axi_rready;
   assign w_last_beat = w_beat & s_axi_wlast;
   assign r_last_beat = r_beat & rlast;
   assign s_axi_bresp = 2'b00;   // okay

   // ########################################################################
   // write channel

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         wr_state      <= WR_IDLE;
         s_axi_awready <= 1'b0;
         s_axi_wready  <= 1'b0;
         s_axi_bvalid  <= 1'b0;
      end
      else
      begin
         case (wr_state)
            WR_IDLE:
               if (aw_accept)
                  wr_state <= WR_DATA;
            WR_DATA:
               if (w_last_beat)
                  wr_state <= WR_RESP;
            default:
               if (s_axi_bvalid && s_axi_bready)
                  wr_state <= WR_IDLE;
         endcase
         s_axi_awready <= (wr_state == WR_IDLE) && !aw_accept;
         // progfull holds off the next beat
         s_axi_wready  <= (wr_state == WR_DATA) && !w_last_beat && !emwr_progfull;
         if (w_last_beat)
            s_axi_bvalid <= 1'b1;
         else if (s_axi_bready)
            s_axi_bvalid <= 1'b0;
      end
   end

   // ########################################################################
   // read channel

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         rd_state      <= RD_IDLE;
         s_axi_arready <= 1'b0;
         read_start    <= 1'b0;
      end
      else
      begin
         case (rd_state)
            RD_IDLE:
               if (ar_accept)
                  rd_state <= RD_DATA;
            default:
               if (r_last_beat)
                  rd_state <= RD_IDLE;
         endcase
         s_axi_arready <= (rd_state == RD_IDLE) && !ar_accept;   // one read at a time
         read_start    <= ar_accept;   // lands on first RD_DATA cycle
      end
   end

   a_bvalid_in_resp : assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
      $rose(s_axi_bvalid) |-> wr_state == WR_RESP);

   a_no_wready_idle : assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
      s_axi_wready |-> wr_state != WR_IDLE);

endmodule

`default_nettype wire

/* design/emesh_write_packer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "bridge_config.svh"

module emesh_write_packer
(
   input  logic                         s_axi_aclk,
   input  logic                         s_axi_aresetn,
   input  logic                         aw_accept,
   input  logic                         w_beat,
   input  axi_types_pkg::axi_addr_t     s_axi_awaddr,
   input  axi_types_pkg::axi_size_t     s_axi_awsize,
   input  axi_types_pkg::axi_burst_e    s_axi_awburst,
   input  axi_types_pkg::axi_data_t     s_axi_wdata,
   input  axi_types_pkg::axi_strb_t     s_axi_wstrb,
   input  emesh_types_pkg::coreid_t     ecfg_coreid,
   input  emesh_types_pkg::ctrlmode_t   ecfg_tx_ctrlmode,
   output logic                         emwr_access,
   output emesh_types_pkg::datamode_t   emwr_datamode,
   output emesh_types_pkg::ctrlmode_t   emwr_ctrlmode,
   output emesh_types_pkg::emesh_addr_t emwr_dstaddr,
   output emesh_types_pkg::emesh_data_t emwr_data
);
   import axi_types_pkg::*;
   import emesh_types_pkg::*;

   emesh_addr_t wr_addr;     // beat address, coreid bits on top
   axi_burst_e  wr_burst;
   datamode_t   wr_mode;
   logic [1:0]  strb_lsb;    // lowest enabled byte lane
   emesh_data_t strb_data;
   logic        pkt_valid;   // delay stage
   emesh_addr_t pkt_addr;
   emesh_data_t pkt_data;

   // address tracker, fixed and wrap stay put
   always_ff @(posedge s_axi_aclk)
   begin
      if (aw_accept)
      begin
         wr_addr  <= {ecfg_coreid[11:`BRIDGE_AXI_ADDR_W-20], s_axi_awaddr};
         wr_burst <= s_axi_awburst;
         wr_mode  <= s_axi_awsize[1:0];
      end
      else if (w_beat && wr_burst == INCR)
      begin
         wr_addr <= {wr_addr[31:2] + 30'd1, 2'b00};   // next word, aligned
      end
   end

   // ########################################################################
   // strobe alignment

   always_comb
   begin
      casez (s_axi_wstrb)
         4'b???1: strb_lsb = 2'd0;
         4'b??10: strb_lsb = 2'd1;
         4'b?100: strb_lsb = 2'd2;
         default: strb_lsb = 2'd3;   // top lane only, or no lane at all
      endcase
   end

   assign strb_data = s_axi_wdata >> {strb_lsb, 3'b000};   // zero fill from the top

   // ########################################################################
   // two stage packet pipe

   always_ff @(posedge s_axi_aclk)
   begin
      if (w_beat)
      begin
         pkt_addr <= {wr_addr[31:2], strb_lsb};
         pkt_data <= strb_data;
      end
      emwr_dstaddr  <= pkt_addr;
      emwr_data     <= pkt_data;
      emwr_datamode <= wr_mode;
      emwr_ctrlmode <= ecfg_tx_ctrlmode;
   end

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         pkt_valid   <= 1'b0;
         emwr_access <= 1'b0;
      end
      else
      begin
         pkt_valid   <= w_beat;
         emwr_access <= pkt_valid;   // two cycles after the beat
      end
   end

endmodule

`default_nettype wire

/* design/emesh_read_requester.sv */
`timescale 1ns/100ps
`default_nettype none

`include "bridge_config.svh"

module emesh_read_requester
(
   input  logic                         s_axi_aclk,
   input  logic                         s_axi_aresetn,
   input  logic                         ar_accept,
   input  logic                         r_beat,
   input  logic                         read_start,
   input  axi_types_pkg::axi_addr_t     s_axi_araddr,
   input  axi_types_pkg::axi_len_t      s_axi_arlen,
   input  axi_types_pkg::axi_size_t     s_axi_arsize,
   input  axi_types_pkg::axi_burst_e    s_axi_arburst,
   input  emesh_types_pkg::coreid_t     ecfg_coreid,
   input  emesh_types_pkg::ctrlmode_t   ecfg_tx_ctrlmode,
   output logic                         s_axi_rlast,
   output axi_types_pkg::axi_size_t     rd_size,
   output logic                         emrq_access,
   output emesh_types_pkg::datamode_t   emrq_datamode,
   output emesh_types_pkg::ctrlmode_t   emrq_ctrlmode,
   output emesh_types_pkg::emesh_addr_t emrq_dstaddr
);
   import axi_types_pkg::*;
   import emesh_types_pkg::*;

   emesh_addr_t rd_addr;       // beat address, coreid bits on top
   axi_len_t    rd_len;        // beats left minus one
   axi_burst_e  rd_burst;
   logic        rnext;         // beat taken, more to come
   logic        req_pending;   // request out, beat not yet taken

   always_ff @(posedge s_axi_aclk)
   begin
      if (ar_accept)
      begin
         rd_addr  <= {ecfg_coreid[11:`BRIDGE_AXI_ADDR_W-20], s_axi_araddr};
         rd_burst <= s_axi_arburst;
         rd_size  <= s_axi_arsize;
      end
      else if (r_beat && rd_burst == INCR)   // captured type, not the live input
      begin
         rd_addr <= {rd_addr[31:2] + 30'd1, 2'b00};
      end
   end

   // beat counter and rlast
   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         rd_len      <= '0;
         s_axi_rlast <= 1'b0;
      end
      else if (ar_accept)
      begin
         rd_len      <= s_axi_arlen;
         s_axi_rlast <= (s_axi_arlen == 8'd0);   // single beat
      end
      else if (r_beat)
      begin
         rd_len <= rd_len - 8'd1;
         if (rd_len == 8'd1)
            s_axi_rlast <= 1'b1;
      end
   end

   // ########################################################################
   // request generation

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         rnext       <= 1'b0;
         emrq_access <= 1'b0;
         req_pending <= 1'b0;
      end
      else
      begin
         rnext       <= r_beat & ~s_axi_rlast;
         emrq_access <= read_start | rnext;
         if (emrq_access)
            req_pending <= 1'b1;
         else if (r_beat)
            req_pending <= 1'b0;
      end
   end

   always_ff @(posedge s_axi_aclk)
   begin
      emrq_dstaddr  <= rd_addr;
      emrq_datamode <= rd_size[1:0];
      emrq_ctrlmode <= ecfg_tx_ctrlmode;
   end

   // the previous beat must be taken before the next request leaves
   a_one_request : assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
      emrq_access |-> !req_pending);

endmodule

`default_nettype wire

/* design/read_response.sv */
`timescale 1ns/100ps
`default_nettype none

module read_response
(
   input  logic                         s_axi_aclk,
   input  logic                         s_axi_aresetn,
   input  logic                         emrr_access,
   input  emesh_types_pkg::emesh_data_t emrr_data,
   input  logic                         local_rd,
   input  emesh_types_pkg::emesh_data_t local_data,
   input  axi_types_pkg::axi_size_t     rd_size,
   input  logic                         s_axi_rready,
   output logic                         s_axi_rvalid,
   output axi_types_pkg::axi_data_t     s_axi_rdata,
   output axi_types_pkg::axi_resp_t     s_axi_rresp,
   output logic                         emrr_rd_en
);
   import emesh_types_pkg::*;

   emesh_data_t rsp_data;   // register block or rx fifo

   assign rsp_data    = local_rd ? local_data : emrr_data;
   assign emrr_rd_en  = emrr_access & ~local_rd;   // pop only for mesh replies
   assign s_axi_rresp = 2'b00;

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
         s_axi_rvalid <= 1'b0;
      else if (emrr_access || local_rd)
         s_axi_rvalid <= 1'b1;
      else if (s_axi_rready)
         s_axi_rvalid <= 1'b0;
   end

   // narrow reads repeat across all lanes
   always_ff @(posedge s_axi_aclk)
   begin
      if (emrr_access || local_rd)
      begin
         case (rd_size[1:0])
            2'b00:   s_axi_rdata <= {4{rsp_data[7:0]}};
            2'b01:   s_axi_rdata <= {2{rsp_data[15:0]}};
            default: s_axi_rdata <= rsp_data;
         endcase
      end
   end

endmodule

`default_nettype wire

/* design/reg_access.sv */
`timescale 1ns/100ps
`default_nettype none

`include "bridge_config.svh"

module reg_access
(
   input  logic                         s_axi_aclk,
   input  logic                         s_axi_aresetn,
   input  logic                         emwr_access,
   input  emesh_types_pkg::emesh_addr_t emwr_dstaddr,
   input  emesh_types_pkg::emesh_data_t emwr_data,
   input  logic                         emrq_access,
   input  emesh_types_pkg::emesh_addr_t emrq_dstaddr,
   output logic                         mi_we,
   output emesh_types_pkg::mi_addr_t    mi_addr,
   output emesh_types_pkg::emesh_data_t mi_din,
   output logic                         mi_ecfg_sel,
   output logic                         mi_rx_emmu_sel,
   output logic                         mi_tx_emmu_sel,
   output logic                         mi_embox_sel,
   input  emesh_types_pkg::emesh_data_t mi_ecfg_dout,
   input  emesh_types_pkg::emesh_data_t mi_rx_emmu_dout,
   input  emesh_types_pkg::emesh_data_t mi_tx_emmu_dout,
   input  emesh_types_pkg::emesh_data_t mi_embox_dout,
   output logic                         local_rd,
   output emesh_types_pkg::emesh_data_t local_data
);

   logic mi_wr;       // write packet hits this link
   logic mi_rd;       // read request hits this link
   logic mi_en;
   logic ecfg_q;      // last cycle's selects steer the readback
   logic rx_emmu_q;
   logic tx_emmu_q;

   assign mi_wr = emwr_access & (emwr_dstaddr[31:20] == `BRIDGE_ELINK_ID);
   assign mi_rd = emrq_access & (emrq_dstaddr[31:20] == `BRIDGE_ELINK_ID);
   assign mi_en = mi_wr | mi_rd;

   assign mi_we   = mi_wr;
   assign mi_addr = mi_wr ? emwr_dstaddr[19:0] : emrq_dstaddr[19:0];   // write wins
   assign mi_din  = emwr_data;

   // group decode on bits 19:16
   assign mi_ecfg_sel    = mi_en & (mi_addr[19:16] == `BRIDGE_GROUP_MMR);
   assign mi_rx_emmu_sel = mi_en & (mi_addr[19:16] == `BRIDGE_GROUP_RXMMU);
   assign mi_tx_emmu_sel = mi_en & (mi_addr[19:16] == `BRIDGE_GROUP_TXMMU);
   assign mi_embox_sel   = mi_en & (mi_addr[19:16] == `BRIDGE_GROUP_EMBOX);

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         ecfg_q    <= 1'b0;
         rx_emmu_q <= 1'b0;
         tx_emmu_q <= 1'b0;
         local_rd  <= 1'b0;
      end
      else
      begin
         ecfg_q    <= mi_ecfg_sel;
         rx_emmu_q <= mi_rx_emmu_sel;
         tx_emmu_q <= mi_tx_emmu_sel;
         local_rd  <= mi_rd;
      end
   end

   // readback mux, mailbox when nothing else matched
   assign local_data = ecfg_q    ? mi_ecfg_dout    :
                       rx_emmu_q ? mi_rx_emmu_dout :
                       tx_emmu_q ? mi_tx_emmu_dout :
                                   mi_embox_dout;

   a_one_select : assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
      $onehot0({mi_ecfg_sel, mi_rx_emmu_sel, mi_tx_emmu_sel, mi_embox_sel}));

endmodule

`default_nettype wire

/* design/axi_emesh_bridge.sv */
`timescale 1ns/100ps
`default_nettype none

module axi_emesh_bridge
(
   input  logic                         s_axi_aclk,
   input  logic                         s_axi_aresetn,
   // write address / data / response
   input  axi_types_pkg::axi_addr_t     s_axi_awaddr,
   input  axi_types_pkg::axi_burst_e    s_axi_awburst,
   input  axi_types_pkg::axi_size_t     s_axi_awsize,
   input  logic                         s_axi_awvalid,
   output logic                         s_axi_awready,
   input  axi_types_pkg::axi_data_t     s_axi_wdata,
   input  axi_types_pkg::axi_strb_t     s_axi_wstrb,
   input  logic                         s_axi_wlast,
   input  logic                         s_axi_wvalid,
   output logic                         s_axi_wready,
   output axi_types_pkg::axi_resp_t     s_axi_bresp,
   output logic                         s_axi_bvalid,
   input  logic                         s_axi_bready,
   // read address / data
   input  axi_types_pkg::axi_addr_t     s_axi_araddr,
   input  axi_types_pkg::axi_burst_e    s_axi_arburst,
   input  axi_types_pkg::axi_len_t      s_axi_arlen,
   input  axi_types_pkg::axi_size_t     s_axi_arsize,
   input  logic                         s_axi_arvalid,
   output logic                         s_axi_arready,
   output axi_types_pkg::axi_data_t     s_axi_rdata,
   output axi_types_pkg::axi_resp_t     s_axi_rresp,
   output logic                         s_axi_rlast,
   output logic                         s_axi_rvalid,
   input  logic                         s_axi_rready,
   // mesh write packets
   output logic                         emwr_access,
   output emesh_types_pkg::datamode_t   emwr_datamode,
   output emesh_types_pkg::ctrlmode_t   emwr_ctrlmode,
   output emesh_types_pkg::emesh_addr_t emwr_dstaddr,
   output emesh_types_pkg::emesh_data_t emwr_data,
   input  logic                         emwr_progfull,
   // mesh read requests
   output logic                         emrq_access,
   output emesh_types_pkg::datamode_t   emrq_datamode,
   output emesh_types_pkg::ctrlmode_t   emrq_ctrlmode,
   output emesh_types_pkg::emesh_addr_t emrq_dstaddr,
   // receive fifo
   input  emesh_types_pkg::emesh_data_t emrr_data,
   input  logic                         emrr_access,
   output logic                         emrr_rd_en,
   // register bus
   output logic                         mi_we,
   output emesh_types_pkg::mi_addr_t    mi_addr,
   output emesh_types_pkg::emesh_data_t mi_din,
   output logic                         mi_ecfg_sel,
   output logic                         mi_rx_emmu_sel,
   output logic                         mi_tx_emmu_sel,
   output logic                         mi_embox_sel,
   input  emesh_types_pkg::emesh_data_t mi_ecfg_dout,
   input  emesh_types_pkg::emesh_data_t mi_rx_emmu_dout,
   input  emesh_types_pkg::emesh_data_t mi_tx_emmu_dout,
   input  emesh_types_pkg::emesh_data_t mi_embox_dout,
   // link config
   input  emesh_types_pkg::ctrlmode_t   ecfg_tx_ctrlmode,
   input  emesh_types_pkg::coreid_t     ecfg_coreid
);
   import axi_types_pkg::*;
   import emesh_types_pkg::*;

   logic        aw_accept;    // handshake pulses from the channel fsm
   logic        w_beat;
   logic        ar_accept;
   logic        r_beat;
   logic        read_start;   // first cycle of a read
   axi_size_t   rd_size;      // captured arsize
   logic        local_rd;     // response comes from the register block
   emesh_data_t local_data;

   axi_slave_ctrl u_ctrl (.rvalid(s_axi_rvalid), .rlast(s_axi_rlast), .*);

   emesh_write_packer u_wr_packer (.*);

   emesh_read_requester u_rd_req (.*);

   read_response u_rd_resp (.*);

   reg_access u_reg (.*);

endmodule

`default_nettype wire

/* tests/tb_axi_emesh_bridge.sv */
`timescale 1ns/100ps
`default_nettype none

`include "bridge_config.svh"

module tb_axi_emesh_bridge;
   import axi_types_pkg::*;

   // ~16 single writes, two bursts, a window write, five reads at < 40 cycles each
   localparam int TEST_CYCLES = 30 * 40;

   logic        s_axi_aclk;
   logic        s_axi_aresetn;
   axi_addr_t   awaddr, araddr;
   axi_burst_e  awburst, arburst;
   axi_size_t   awsize, arsize;
   axi_len_t    arlen;
   logic        awvalid, awready, wlast, wvalid, wready, bvalid, bready;
   axi_data_t   wdata, rdata;
   axi_strb_t   wstrb;
   axi_resp_t   bresp, rresp;
   logic        arvalid, arready, rlast, rvalid, rready;
   logic        emwr_access, emwr_progfull, emrq_access, emrr_access, emrr_rd_en;
   logic [1:0]  emwr_datamode, emrq_datamode;
   logic [3:0]  emwr_ctrlmode, emrq_ctrlmode, ctrlmode;
   logic [31:0] emwr_dstaddr, emwr_data, emrq_dstaddr, emrr_data, mi_din;
   logic        mi_we, mi_ecfg_sel, mi_rx_emmu_sel, mi_tx_emmu_sel, mi_embox_sel;
   logic [19:0] mi_addr;
   logic [31:0] ecfg_dout, rx_dout, tx_dout, embox_dout;
   logic [11:0] coreid;

   logic [31:0] lfsr = 32'h7f1b7148;
   int          errors = 0;
   int          bvalid_count = 0;
   int          rd_en_count = 0;
   int          mi_count = 0;
   logic        bvalid_q = 1'b0;
   logic [31:0] wr_addr_q[$], wr_data_q[$], rq_addr_q[$], rr_data_q[$];
   logic [1:0]  wr_mode_q[$];
   logic [3:0]  wr_ctrl_q[$];
   logic [1:0]  rq_mode_q[$];
   logic [3:0]  rq_ctrl_q[$];
   logic [19:0] mi_addr_last;
   logic [31:0] mi_din_last;
   logic [3:0]  mi_sel_last;
   logic [31:0] rr_word;   // reply word of the rx fifo model
   axi_data_t   beat_data[0:7];
   axi_strb_t   beat_strb[0:7];

   axi_emesh_bridge uut
   (
      .s_axi_aclk, .s_axi_aresetn,
      .s_axi_awaddr(awaddr), .s_axi_awburst(awburst), .s_axi_awsize(awsize),
      .s_axi_awvalid(awvalid), .s_axi_awready(awready),
      .s_axi_wdata(wdata), .s_axi_wstrb(wstrb), .s_axi_wlast(wlast),
      .s_axi_wvalid(wvalid), .s_axi_wready(wready),
      .s_axi_bresp(bresp), .s_axi_bvalid(bvalid), .s_axi_bready(bready),
      .s_axi_araddr(araddr), .s_axi_arburst(arburst), .s_axi_arlen(arlen),
      .s_axi_arsize(arsize), .s_axi_arvalid(arvalid), .s_axi_arready(arready),
      .s_axi_rdata(rdata), .s_axi_rresp(rresp), .s_axi_rlast(rlast),
      .s_axi_rvalid(rvalid), .s_axi_rready(rready),
      .emwr_access, .emwr_datamode, .emwr_ctrlmode, .emwr_dstaddr, .emwr_data,
      .emwr_progfull, .emrq_access, .emrq_datamode, .emrq_ctrlmode, .emrq_dstaddr,
      .emrr_data, .emrr_access, .emrr_rd_en,
      .mi_we, .mi_addr, .mi_din, .mi_ecfg_sel, .mi_rx_emmu_sel, .mi_tx_emmu_sel,
      .mi_embox_sel, .mi_ecfg_dout(ecfg_dout), .mi_rx_emmu_dout(rx_dout),
      .mi_tx_emmu_dout(tx_dout), .mi_embox_dout(embox_dout),
      .ecfg_tx_ctrlmode(ctrlmode), .ecfg_coreid(coreid)
   );

   initial
   begin
      s_axi_aclk = 1'b0;
      forever #5 s_axi_aclk = ~s_axi_aclk;
   end

   initial
   begin
      #(TEST_CYCLES * 10);
      $display("watchdog: simulation did not finish in time");
      $display("=== FAIL ===");
      $finish;
   end

   // ########################################################################
   // models and monitors sampled on the falling edge

   always @(negedge s_axi_aclk)
   begin
      if (emwr_access)
      begin
         wr_addr_q.push_back(emwr_dstaddr);
         wr_data_q.push_back(emwr_data);
         wr_mode_q.push_back(emwr_datamode);
         wr_ctrl_q.push_back(emwr_ctrlmode);
      end
      if (emrq_access)
      begin
         rq_addr_q.push_back(emrq_dstaddr);
         rq_mode_q.push_back(emrq_datamode);
         rq_ctrl_q.push_back(emrq_ctrlmode);
      end
      if (bvalid && !bvalid_q)
         bvalid_count++;
      bvalid_q = bvalid;
      if (mi_we)
      begin
         mi_count++;
         mi_addr_last = mi_addr;
         mi_din_last  = mi_din;
         mi_sel_last  = {mi_ecfg_sel, mi_rx_emmu_sel, mi_tx_emmu_sel, mi_embox_sel};
      end
   end

   // rx fifo model answers every remote request
   always @(negedge s_axi_aclk)
   begin
      if (emrr_rd_en)
         rd_en_count++;   // settled since the last edge
      if (emrq_access && emrq_dstaddr[31:20] != `BRIDGE_ELINK_ID)
      begin
         rr_word     = next_word();
         emrr_access = 1'b1;
         emrr_data   = rr_word;
         rr_data_q.push_back(rr_word);
      end
      else
         emrr_access = 1'b0;
   end

   // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
   function automatic logic [31:0] next_word();
      logic [31:0] w;
      w = '0;
      for (int i = 0; i < 32; i++)
      begin
         lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
         w    = {w[30:0], lfsr[0]};
      end
      return w;
   endfunction

   task automatic check(input logic ok, input string msg);
      if (!ok)
      begin
         errors++;
         $display("error at %0t ns: %s", $time, msg);
      end
   endtask

   task automatic report(input string name, input int errs_before);
      if (errors == errs_before)
         $display("%s: ok", name);
      else
         $display("%s: failed with %0d errors", name, errors - errs_before);
   endtask

   // ########################################################################
   // bus tasks

   task automatic write_burst(input axi_addr_t addr, input axi_burst_e burst,
                              input axi_size_t size, input int n, input int stall_at);
      int          b0;
      int          k;
      logic [31:0] word;
      b0 = bvalid_count;
      wr_addr_q.delete();
      wr_data_q.delete();
      wr_mode_q.delete();
      wr_ctrl_q.delete();
      @(negedge s_axi_aclk);
      while (!awready)
         @(negedge s_axi_aclk);
      awaddr  = addr;
      awburst = burst;
      awsize  = size;
      awvalid = 1'b1;
      @(negedge s_axi_aclk);
      awvalid = 1'b0;
      for (int i = 0; i < n; i++)
      begin
         while (!wready)
            @(negedge s_axi_aclk);
         wvalid = 1'b1;
         wdata  = beat_data[i];
         wstrb  = beat_strb[i];
         wlast  = (i == n - 1);
         if (i == stall_at)
            emwr_progfull = 1'b1;   // back-pressure after this beat
         @(negedge s_axi_aclk);
         wvalid = 1'b0;
         if (i == stall_at)
         begin
            repeat (3) @(negedge s_axi_aclk)
               check(!wready, "wready high while progfull is set");
            check(wr_addr_q.size() == i + 1, "packet count wrong during stall");
            emwr_progfull = 1'b0;
         end
      end
      while (wr_addr_q.size() < n || bvalid_count == b0)
         @(negedge s_axi_aclk);
      check(bresp == 2'b00, "bresp not okay");
      repeat (4) @(negedge s_axi_aclk);
      check(bvalid_count == b0 + 1, "bvalid count after burst not one");
      check(wr_addr_q.size() == n, "extra write packets");
      for (int i = 0; i < n; i++)
      begin
         k = 3;
         for (int b = 3; b >= 0; b--)
            if (beat_strb[i][b])
               k = b;
         word = {coreid[11:10], addr} >> 2;
         if (burst == INCR)
            word = word + 32'(i);
         check(wr_addr_q[i] == {word[29:0], 2'(k)}, $sformatf("beat %0d dstaddr %h",
               i, wr_addr_q[i]));
         check(wr_data_q[i] == beat_data[i] >> (8 * k), $sformatf("beat %0d data %h",
               i, wr_data_q[i]));
         check(wr_mode_q[i] == size[1:0], "datamode differs from awsize");
         check(wr_ctrl_q[i] == ctrlmode, "ctrlmode not passed through");
      end
   endtask

   task automatic read_burst(input axi_addr_t addr, input axi_burst_e burst,
                             input axi_size_t size, input axi_len_t len,
                             input logic [31:0] local_word);
      logic [31:0] src;
      logic [31:0] exp;
      logic [31:0] word;
      int          e0;
      e0 = rd_en_count;
      rq_addr_q.delete();
      rq_mode_q.delete();
      rq_ctrl_q.delete();
      rr_data_q.delete();
      @(negedge s_axi_aclk);
      while (!arready)
         @(negedge s_axi_aclk);
      araddr  = addr;
      arburst = burst;
      arsize  = size;
      arlen   = len;
      arvalid = 1'b1;
      @(negedge s_axi_aclk);
      arvalid = 1'b0;
      for (int i = 0; i <= int'(len); i++)
      begin
         while (!rvalid)
            @(negedge s_axi_aclk);
         src = (rr_data_q.size() > i) ? rr_data_q[i] : local_word;
         case (size)
            3'd0:    exp = {4{src[7:0]}};
            3'd1:    exp = {2{src[15:0]}};
            default: exp = src;
         endcase
         check(rdata == exp, $sformatf("beat %0d rdata %h expected %h", i, rdata, exp));
         check(rlast == (i == int'(len)), $sformatf("beat %0d rlast %b", i, rlast));
         check(rresp == 2'b00, "rresp not okay");
         @(negedge s_axi_aclk);
      end
      check(rq_addr_q.size() == int'(len) + 1, "wrong request count");
      for (int i = 0; i < rq_addr_q.size(); i++)
      begin
         word = ({coreid[11:10], addr} >> 2) + ((burst == INCR) ? 32'(i) : 32'd0);
         exp  = (i == 0) ? {coreid[11:10], addr} : {word[29:0], 2'b00};
         check(rq_addr_q[i] == exp, $sformatf("request %0d addr %h", i, rq_addr_q[i]));
         check(rq_mode_q[i] == size[1:0], "request datamode differs from arsize");
         check(rq_ctrl_q[i] == ctrlmode, "request ctrlmode not passed through");
      end
      check(rd_en_count - e0 == rr_data_q.size(), "emrr_rd_en count wrong");
   endtask

   // ########################################################################
   // tests

   task automatic reset_outputs();
      int e;
      e = errors;
      repeat (9)
      begin
         @(negedge s_axi_aclk);
         check({awready, wready, bvalid, arready, rvalid, rlast, emwr_access,
                emrq_access, emrr_rd_en, mi_ecfg_sel, mi_rx_emmu_sel, mi_tx_emmu_sel,
                mi_embox_sel} == '0, "output high during reset");
      end
      @(negedge s_axi_aclk);
      s_axi_aresetn = 1'b1;
      repeat (2) @(negedge s_axi_aclk);
      check(awready && arready, "awready or arready low after reset");
      report("reset state", e);
   endtask

   task automatic single_write_strobes();
      int e;
      e = errors;
      for (int s = 0; s < 16; s++)
      begin
         beat_data[0] = next_word();
         beat_strb[0] = 4'(s);
         write_burst(30'h1234_5678 + 30'(4 * s), INCR, 3'd2, 1, -1);
      end
      check(mi_count == 0, "remote write reached the register bus");
      report("strobe alignment", e);
   endtask

   task automatic burst_writes();
      int e;
      e = errors;
      for (int i = 0; i < 4; i++)
      begin
         beat_data[i] = next_word();
         beat_strb[i] = 4'hf;
      end
      write_burst(30'h2345_0100, INCR, 3'd2, 4, 1);
      write_burst(30'h2345_0200, FIXED, 3'd2, 3, -1);
      report("bursts and back-pressure", e);
   endtask

   task automatic window_write();
      int e;
      int m0;
      e  = errors;
      m0 = mi_count;
      beat_data[0] = next_word();
      beat_strb[0] = 4'hf;
      write_burst({10'h010, `BRIDGE_GROUP_MMR, 16'h0040}, INCR, 3'd2, 1, -1);
      check(mi_count == m0 + 1, "mi_we count wrong");
      check(mi_sel_last == 4'b1000, "wrong group select");
      check(mi_addr_last == {`BRIDGE_GROUP_MMR, 16'h0040}, "mi_addr differs from packet");
      check(mi_din_last == beat_data[0], "mi_din differs from packet");
      report("register window write", e);
   endtask

   task automatic remote_byte_read();
      int e;
      e = errors;
      read_burst(30'h0567_8121, INCR, 3'd0, 8'd1, 32'h0);
      report("remote byte read", e);
   endtask

   task automatic local_register_reads();
      int          e;
      logic [3:0]  grp[4];
      logic [31:0] val[4];
      e = errors;
      grp = '{`BRIDGE_GROUP_MMR, `BRIDGE_GROUP_RXMMU, `BRIDGE_GROUP_TXMMU,
              `BRIDGE_GROUP_EMBOX};
      val = '{ecfg_dout, rx_dout, tx_dout, embox_dout};
      for (int g = 0; g < 4; g++)
         read_burst({10'h010, grp[g], 16'h0010}, INCR, 3'd2, 8'd0, val[g]);
      report("local register reads", e);
   endtask

   initial
   begin
      s_axi_aresetn = 1'b0;
      {awvalid, wvalid, wlast, arvalid, emwr_progfull, emrr_access} = '0;
      bready = 1'b1;
      rready = 1'b1;
      awaddr = '0;
      araddr = '0;
      awburst = INCR;
      arburst = INCR;
      awsize = '0;
      arsize = '0;
      arlen = '0;
      wdata = '0;
      wstrb = '0;
      emrr_data = '0;
      coreid = 12'h810;   // window is address bits 29:20 == 10'h010
      ctrlmode = 4'h5;
      ecfg_dout  = 32'hec0f_0001;
      rx_dout    = 32'h5a11_0002;
      tx_dout    = 32'h7e22_0003;
      embox_dout = 32'hb0b0_0004;
      reset_outputs();
      single_write_strobes();
      burst_writes();
      window_write();
      remote_byte_read();
      local_register_reads();
      $display("tests done, %0d errors", errors);
      if (errors == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

`default_nettype wire

/* compile.f */
+incdir+design
design/axi_types_pkg.sv
design/emesh_types_pkg.sv
design/axi_slave_ctrl.sv
design/emesh_write_packer.sv
design/emesh_read_requester.sv
design/read_response.sv
design/reg_access.sv
design/axi_emesh_bridge.sv
tests/tb_axi_emesh_bridge.sv

/* run_sim.sh */
#!/bin/bash
# build and run with Verilator, failure decided from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f compile.f --top-module tb_axi_emesh_bridge \
   -Mdir obj_dir -o sim_bin > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_bin > sim.log 2>&1
cat sim.log
! grep -q "=== FAIL ===" sim.log && grep -q "=== PASS ===" sim.log || exit 1
